// File: Makefile
# Verilator build and run of the ecfg testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Mdir obj_dir --top-module ecfg_tb -f sources.f
	@out="$$(./obj_dir/Vecfg_tb)"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// File: bench/ecfg_model.svh
/*
  ecfg reference model
  copies of the soft-reset and pll registers, plus queues of
  expected replies and expected register outputs with due cycles
*/
`ifndef ECFG_MODEL_SVH
`define ECFG_MODEL_SVH

typedef struct packed {
  int      due;  // cycle the reply must show up
  packet_t pkt;
} rr_exp_t;

typedef struct packed {
  int       due;  // cycle the write must be visible
  logic     rst;
  clk_cfg_t clk;
} wr_exp_t;

logic     m_reset;  // model soft reset
clk_cfg_t m_clk;    // model pll word
rr_exp_t  rr_q[$];  // replies in order of arrival
wr_exp_t  wr_q[$];

task automatic model_reset();
  m_reset = 1'b0;
  m_clk   = '0;
  rr_q.delete();
  wr_q.delete();
endtask

// reply source, core ID and config group only
function automatic addr_t resp_src();
  return {DUT_ID, 9'h000, 3'd2, 8'h00};
endfunction

function automatic logic model_hit(input packet_t p);
  addr_t dst;
  dst = p[39:8];
  return (dst[31:20] == DUT_ID) && (dst[10:8] == 3'd2);
endfunction

// word index is addr[7:2] with a 6-bit register space
function automatic data_t model_read(input logic [5:0] idx);
  case (idx)
    6'd0:    return {31'h0, m_reset};
    6'd1:    return {16'h0, m_clk};
    6'd2:    return {20'h0, DUT_ID};
    6'd3:    return 32'h0000_0102;  // version 1.2
    default: return 32'h0;
  endcase
endfunction

// c is the cycle count at the edge that drives the packet
task automatic model_accept(input logic acc, input packet_t p, input int c);
  logic       wr;
  addr_t      dst;
  data_t      dat;
  addr_t      src;
  logic [5:0] idx;
  rr_exp_t    e;
  wr_exp_t    w;
  wr  = p[0];
  dst = p[39:8];
  dat = p[71:40];
  src = p[103:72];
  idx = dst[7:2];
  if (acc && model_hit(p)) begin
    if (wr) begin
      if (idx == 6'd0) m_reset = dat[0];      // bit 0 only
      if (idx == 6'd1) m_clk = dat[15:0];     // low half
    end else begin
      e.due = c + 4;  // 3 cycles after the sampling edge
      e.pkt = {resp_src(), model_read(idx), src, 5'h00, 2'b00, 1'b1};
      rr_q.push_back(e);
    end
  end
  // hit or miss, outputs must match the model 2 cycles on
  if (acc && wr) begin
    w.due = c + 3;
    w.rst = m_reset;
    w.clk = m_clk;
    wr_q.push_back(w);
  end
endtask

`endif

// File: bench/ecfg_tb.sv
/*
  ecfg testbench
  drives mesh write packets into the config slice and checks
  register outputs and read replies against a reference model,
  directed tests first, then random back-to-back traffic
*/
`timescale 1ns/1ps

module ecfg_tb;
  import ecfg_pkg::*;

  localparam logic [11:0] DUT_ID = 12'h810;
  localparam int          N_RAND = 2000;

  logic     clk = 1'b0;
  logic     hard_reset;
  logic     txwr_access;
  packet_t  txwr_packet;
  logic     soft_reset;
  clk_cfg_t ecfg_clk_settings;
  logic     rr_access;
  packet_t  rr_packet;

  int cyc;                // rising edges so far
  int seed = 32'h96a1;
  int err_count;
  int test_errs;          // error count when the test began
  int tests_run;
  int tests_failed;
  bit checking;           // off during reset

  `include "ecfg_model.svh"

  ecfg_top #(.ID(DUT_ID), .RFAW(6)) i_dut (
    .clk               (clk),
    .hard_reset        (hard_reset),
    .txwr_access       (txwr_access),
    .txwr_packet       (txwr_packet),
    .soft_reset        (soft_reset),
    .ecfg_clk_settings (ecfg_clk_settings),
    .rr_access         (rr_access),
    .rr_packet         (rr_packet)
  );

  always #2 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  //####################
  // checker, falling edge, outputs settled
  always @(negedge clk) begin
    if (checking) begin
      if (rr_access) begin
        if (rr_q.size() == 0) begin
          $display("reply with none expected at cycle %0d", cyc);
          err_count++;
        end else begin
          if (rr_q[0].due != cyc) begin
            $display("reply at cycle %0d, due at %0d", cyc, rr_q[0].due);
            err_count++;
          end
          if (rr_packet !== rr_q[0].pkt) begin
            $display("MISMATCH rr_packet got %h expected %h", rr_packet, rr_q[0].pkt);
            err_count++;
          end
          void'(rr_q.pop_front());
        end
      end else if (rr_q.size() != 0 && rr_q[0].due <= cyc) begin
        $display("reply due at cycle %0d never came", rr_q[0].due);
        err_count++;
        void'(rr_q.pop_front());
      end
      if (wr_q.size() != 0 && wr_q[0].due <= cyc) begin
        if (soft_reset !== wr_q[0].rst) begin
          $display("MISMATCH soft_reset got %h expected %h", soft_reset, wr_q[0].rst);
          err_count++;
        end
        if (ecfg_clk_settings !== wr_q[0].clk) begin
          $display("MISMATCH ecfg_clk_settings got %h expected %h",
                   ecfg_clk_settings, wr_q[0].clk);
          err_count++;
        end
        void'(wr_q.pop_front());
      end
    end
  end

  //####################
  // stimulus helpers
  function automatic packet_t make_pkt(input logic wr, input addr_t dst,
                                       input data_t dat, input addr_t src);
    return {src, dat, dst, 5'h00, 2'b00, wr};
  endfunction

  function automatic addr_t reg_addr(input logic [11:0] id, input logic [2:0] grp,
                                     input logic [5:0] idx);
    return {id, 9'h000, grp, idx, 2'b00};
  endfunction

  task automatic send(input logic acc, input packet_t p);
    @(posedge clk);
    txwr_access <= acc;
    txwr_packet <= p;
    model_accept(acc, p, cyc);  // cyc still holds the pre-edge count
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      txwr_access <= 1'b0;
    end
  endtask

  // mostly hits on mapped words, some foreign cores and groups
  task automatic rand_packet(output logic acc, output packet_t p);
    logic [31:0] r;
    logic [31:0] fill;
    logic [11:0] id;
    logic [2:0]  grp;
    logic [5:0]  idx;
    r    = $random(seed);
    fill = $random(seed);
    id   = (r[3:0] == 4'h0) ? (DUT_ID ^ {r[15:5], 1'b1}) : DUT_ID;
    grp  = (r[18:16] == 3'h0) ? (3'd2 ^ {r[20:19], 1'b1}) : 3'd2;
    idx  = r[21] ? {3'b000, r[24:22]} : fill[5:0];
    acc  = (r[27:25] != 3'h0);  // 1 in 8 without strobe
    p    = make_pkt(r[28], {id, fill[14:6], grp, idx, fill[16:15]},
                    $random(seed), $random(seed));
    p[7:1] = fill[23:17];  // datamode and ctrlmode are don't care
  endtask

  // wait for all expected replies and writes, bounded
  task automatic drain();
    int n;
    idle(1);
    @(negedge clk);
    n = 0;
    while ((rr_q.size() != 0 || wr_q.size() != 0) && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (n >= 20) begin
      $display("timeout, replies or writes still pending after 20 cycles");
      err_count++;
      rr_q.delete();
      wr_q.delete();
    end
  endtask

  task automatic check_regs();
    if (soft_reset !== m_reset) begin
      $display("MISMATCH soft_reset got %h expected %h", soft_reset, m_reset);
      err_count++;
    end
    if (ecfg_clk_settings !== m_clk) begin
      $display("MISMATCH ecfg_clk_settings got %h expected %h", ecfg_clk_settings, m_clk);
      err_count++;
    end
  endtask

  task automatic end_test(input string name);
    int n;
    n = err_count - test_errs;
    tests_run++;
    if (n == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, n);
    end
    test_errs = err_count;
  endtask

  //####################
  // test sequence
  initial begin
    int      i;
    logic    acc;
    packet_t p;
    hard_reset  <= 1'b1;
    txwr_access <= 1'b0;
    txwr_packet <= '0;
    model_reset();
    repeat (5) @(posedge clk);
    hard_reset <= 1'b0;
    @(negedge clk);
    checking = 1'b1;

    check_regs();  // reset values
    idle(10);      // any reply here is flagged
    end_test("reset");

    send(1'b1, make_pkt(1'b1, reg_addr(DUT_ID, 3'd2, 6'd0), 32'h0000_0001, '0));
    send(1'b1, make_pkt(1'b1, reg_addr(DUT_ID, 3'd2, 6'd1), 32'habcd_1234, '0));
    send(1'b1, make_pkt(1'b1, reg_addr(DUT_ID, 3'd2, 6'd2), 32'hffff_ffff, '0));
    send(1'b1, make_pkt(1'b1, reg_addr(DUT_ID, 3'd2, 6'd3), 32'hffff_ffff, '0));
    drain();
    check_regs();
    end_test("writes");

    send(1'b1, make_pkt(1'b0, reg_addr(DUT_ID, 3'd2, 6'd0), '0, 32'h1234_5000));
    send(1'b1, make_pkt(1'b0, reg_addr(DUT_ID, 3'd2, 6'd1), '0, 32'h1234_5004));
    send(1'b1, make_pkt(1'b0, reg_addr(DUT_ID, 3'd2, 6'd2), '0, 32'h1234_5008));
    send(1'b1, make_pkt(1'b0, reg_addr(DUT_ID, 3'd2, 6'd3), '0, 32'h1234_500c));
    send(1'b1, make_pkt(1'b0, reg_addr(DUT_ID, 3'd2, 6'd5), '0, 32'h1234_5010));  // unmapped
    drain();
    end_test("reads");

    send(1'b1, make_pkt(1'b1, reg_addr(DUT_ID ^ 12'h001, 3'd2, 6'd1), 32'h5555, '0));
    send(1'b1, make_pkt(1'b1, reg_addr(DUT_ID, 3'd3, 6'd0), 32'h0, '0));
    send(1'b0, make_pkt(1'b1, reg_addr(DUT_ID, 3'd2, 6'd1), 32'hffff, '0));
    send(1'b1, make_pkt(1'b0, reg_addr(DUT_ID ^ 12'h100, 3'd2, 6'd0), '0, 32'h77));
    send(1'b1, make_pkt(1'b0, reg_addr(DUT_ID, 3'd6, 6'd1), '0, 32'h88));
    send(1'b0, make_pkt(1'b0, reg_addr(DUT_ID, 3'd2, 6'd2), '0, 32'h99));
    drain();
    check_regs();
    end_test("misses");

    for (i = 0; i < N_RAND; i++) begin
      if (($random(seed) & 7) == 0) idle(1);
      rand_packet(acc, p);
      send(acc, p);
    end
    drain();
    check_regs();
    end_test("random");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // whole-run watchdog
  initial begin
    #100000;
    $display("timeout, simulation did not finish");
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: hdl/ecfg_clocks.sv
/*
  ecfg clocks
  decodes mesh transactions against the core ID and the config
  group, holds the soft-reset bit and the pll clock settings,
  and returns a registered read response for the four registers
*/
`timescale 1ns/1ps

module ecfg_clocks #(
  parameter logic [11:0] ID   = 12'h000,  // core ID, addr[31:20]
  parameter int          RFAW = 6         // register address width
) (
  input  logic                clk,
  input  logic                hard_reset,   // only reset of these regs
  input  ecfg_pkg::mesh_txn_t txn,
  output logic                soft_reset,
  output ecfg_pkg::clk_cfg_t  ecfg_clk_settings,
  output ecfg_pkg::rd_resp_t  rd_resp
);
  import ecfg_pkg::*;

  logic        mi_en;       // access hits this block
  logic        ecfg_write;
  logic        ecfg_read;
  int unsigned reg_idx;     // word index, addr[RFAW+1:2]
  logic        reset_write;
  logic        clk_write;

  logic        reset_reg;
  clk_cfg_t    clk_reg;

  data_t       rd_data;     // mux out, before the register
  logic        rd_valid_q;
  addr_t       rd_addr_q;
  data_t       rd_data_q;

  //####################
  // address decode
  assign mi_en = txn.access &&
                 (txn.dstaddr[31:20] == ID) &&
                 (txn.dstaddr[10:8] == ECFG_GROUP);

  assign ecfg_write = mi_en &  txn.write;
  assign ecfg_read  = mi_en & ~txn.write;

  assign reg_idx = 32'(txn.dstaddr[RFAW+1:2]);

  // only two writable words, the rest are dropped
  assign reset_write = ecfg_write && (reg_idx == E_RESET);
  assign clk_write   = ecfg_write && (reg_idx == E_CLK);

  //####################
  // soft reset
  always_ff @(posedge clk or posedge hard_reset) begin
    if (hard_reset) begin
      reset_reg <= 1'b0;
    end else if (reset_write) begin
      reset_reg <= txn.data[0];  // bit 0 only
    end
  end

  assign soft_reset = reset_reg;

  //####################
  // pll settings
  always_ff @(posedge clk or posedge hard_reset) begin
    if (hard_reset) begin
      clk_reg <= '0;
    end else if (clk_write) begin
      clk_reg <= txn.data[CLKW-1:0];  // low half
    end
  end

  assign ecfg_clk_settings = clk_reg;

  //####################
  // read mux
  always_comb begin
    case (reg_idx)
      E_RESET:   rd_data = {31'b0, reset_reg};
      E_CLK:     rd_data = {16'b0, clk_reg};
      E_COREID:  rd_data = {20'b0, ID};           // ID is fixed per core
      E_VERSION: rd_data = {16'b0, ECFG_VERSION};
      default:   rd_data = '0;                    // unmapped word
    endcase
  end

  // response strobe
  always_ff @(posedge clk or posedge hard_reset) begin
    if (hard_reset) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= ecfg_read;
    end
  end

  // response payload, held between reads
  always_ff @(posedge clk) begin
    if (ecfg_read) begin
      rd_addr_q <= txn.srcaddr;  // reply goes back to requester
      rd_data_q <= rd_data;
    end
  end

  assign rd_resp = '{valid: rd_valid_q, addr: rd_addr_q, data: rd_data_q};

  //####################
  // checks
  property p_rw_exclusive;
    @(posedge clk) disable iff (hard_reset)
      !(ecfg_read && ecfg_write);
  endproperty
  a_rw_exclusive : assert property (p_rw_exclusive);

  // a reply only ever follows a live transaction
  property p_resp_needs_access;
    @(posedge clk) disable iff (hard_reset)
      !txn.access |=> !rd_resp.valid;
  endproperty
  a_resp_needs_access : assert property (p_resp_needs_access);

endmodule

// File: hdl/ecfg_pkg.sv
/*
  ecfg package
  mesh packet layout and field offsets, the unpacked transaction,
  the read response handed to the output stage, and the register
  map of the config block (group, indices, version)
*/
package ecfg_pkg;

  //####################
  // widths
  localparam int PW      = 104; // whole mesh packet, fixed by format
  localparam int AW      = 32;  // address word
  localparam int DW      = 32;  // data word
  localparam int CLKW    = 16;  // pll settings word
  localparam int DMODE_W = 2;
  localparam int CMODE_W = 5;

  typedef logic [PW-1:0]   packet_t;
  typedef logic [AW-1:0]   addr_t;
  typedef logic [DW-1:0]   data_t;
  typedef logic [CLKW-1:0] clk_cfg_t;

  //####################
  // packet layout, lsb of each field
  localparam int P_WRITE = 0;   // single bit
  localparam int P_DMODE = 1;   // 2..1
  localparam int P_CMODE = 3;   // 7..3
  localparam int P_DST   = 8;   // 39..8
  localparam int P_DATA  = 40;  // 71..40
  localparam int P_SRC   = 72;  // 103..72

  // one transaction after unpacking
  typedef struct packed {
    logic               access;   // one cycle per packet
    logic               write;
    logic [DMODE_W-1:0] datamode;
    logic [CMODE_W-1:0] ctrlmode;
    addr_t              dstaddr;
    data_t              data;
    addr_t              srcaddr;  // where a read reply goes
  } mesh_txn_t;

  // read reply, register stage to output stage
  typedef struct packed {
    logic  valid;
    addr_t addr;  // requester srcaddr
    data_t data;
  } rd_resp_t;

  //####################
  // register map
  localparam logic [2:0] ECFG_GROUP = 3'd2; // matched on addr[10:8]

  localparam int unsigned E_RESET   = 0;   // rw, bit 0
  localparam int unsigned E_CLK     = 1;   // rw, 16 bits
  localparam int unsigned E_COREID  = 2;   // ro
  localparam int unsigned E_VERSION = 3;   // ro

  localparam logic [15:0] ECFG_VERSION = 16'h0102;

endpackage

// File: hdl/ecfg_readback.sv
/*
  ecfg readback
  output stage: packs a read response into the mesh layout,
  addressed to the requester, with this block as the source,
  and registers the packet together with its access pulse
*/
`timescale 1ns/1ps

module ecfg_readback #(
  parameter logic [11:0] ID = 12'h000  // core ID for the reply srcaddr
) (
  input  logic               clk,
  input  logic               hard_reset,
  input  ecfg_pkg::rd_resp_t rd_resp,
  output logic               rr_access,
  output ecfg_pkg::packet_t  rr_packet
);
  import ecfg_pkg::*;

  addr_t   self_addr;  // source address of every reply
  packet_t resp_pkt;   // packed, before the register

  assign self_addr = {ID, 9'b0, ECFG_GROUP, 8'b0};

  //####################
  // pack
  always_comb begin
    resp_pkt                       = '0;
    resp_pkt[P_WRITE]              = 1'b1;     // replies travel as writes
    resp_pkt[P_DMODE +: DMODE_W]   = '0;       // word
    resp_pkt[P_CMODE +: CMODE_W]   = '0;
    resp_pkt[P_DST +: AW]          = rd_resp.addr;
    resp_pkt[P_DATA +: DW]         = rd_resp.data;
    resp_pkt[P_SRC +: AW]          = self_addr;
  end

  //####################
  // strobe
  always_ff @(posedge clk or posedge hard_reset) begin
    if (hard_reset) begin
      rr_access <= 1'b0;
    end else begin
      rr_access <= rd_resp.valid;  // one pulse per reply
    end
  end

  // packet, loads with each reply
  always_ff @(posedge clk) begin
    if (rd_resp.valid) begin
      rr_packet <= resp_pkt;
    end
  end

  //####################
  // checks
  property p_rr_follows_resp;
    @(posedge clk) disable iff (hard_reset)
      rr_access |-> $past(rd_resp.valid);
  endproperty
  a_rr_follows_resp : assert property (p_rr_follows_resp);

endmodule

// File: hdl/ecfg_top.sv
/*
  ecfg top
  configuration slice of the mesh interface: input unpack,
  register decode with soft reset and pll settings, and the
  read-response output stage, three cycles request to reply
*/
`timescale 1ns/1ps

module ecfg_top #(
  parameter logic [11:0] ID   = 12'h810,  // this core
  parameter int          RFAW = 6
) (
  input  logic               clk,
  input  logic               hard_reset,
  // mesh transmit-write in
  input  logic               txwr_access,
  input  ecfg_pkg::packet_t  txwr_packet,
  // config outputs
  output logic               soft_reset,
  output ecfg_pkg::clk_cfg_t ecfg_clk_settings,
  // mesh read response out
  output logic               rr_access,
  output ecfg_pkg::packet_t  rr_packet
);
  import ecfg_pkg::*;

  mesh_txn_t txn;      // unpack -> decode
  rd_resp_t  rd_resp;  // decode -> readback

  //####################
  // input side
  emesh_unpack i_unpack (
    .clk         (clk),
    .hard_reset  (hard_reset),
    .txwr_access (txwr_access),
    .txwr_packet (txwr_packet),
    .txn         (txn)
  );

  //####################
  // registers
  ecfg_clocks #(
    .ID   (ID),
    .RFAW (RFAW)
  ) i_clocks (
    .clk               (clk),
    .hard_reset        (hard_reset),
    .txn               (txn),
    .soft_reset        (soft_reset),
    .ecfg_clk_settings (ecfg_clk_settings),
    .rd_resp           (rd_resp)
  );

  //####################
  // output side
  ecfg_readback #(
    .ID (ID)
  ) i_readback (
    .clk        (clk),
    .hard_reset (hard_reset),
    .rd_resp    (rd_resp),
    .rr_access  (rr_access),
    .rr_packet  (rr_packet)
  );

endmodule

// File: hdl/emesh_unpack.sv
/*
  emesh unpack
  input stage of the config slice: registers the transmit-write
  strobe and the 104-bit packet, then splits the packet into
  transaction fields by the mesh layout
*/
`timescale 1ns/1ps

module emesh_unpack (
  input  logic                clk,
  input  logic                hard_reset,
  input  logic                txwr_access,
  input  ecfg_pkg::packet_t   txwr_packet,
  output ecfg_pkg::mesh_txn_t txn
);
  import ecfg_pkg::*;

  logic    access_q;  // strobe copy
  packet_t packet_q;  // payload copy

  //####################
  // strobe, cleared by reset
  always_ff @(posedge clk or posedge hard_reset) begin
    if (hard_reset) begin
      access_q <= 1'b0;
    end else begin
      access_q <= txwr_access;  // one pulse per packet, kept one cycle
    end
  end

  //####################
  // payload, loads only with a packet
  always_ff @(posedge clk) begin
    if (txwr_access) begin
      packet_q <= txwr_packet;
    end
  end

  //####################
  // field split
  always_comb begin
    txn.access   = access_q;
    txn.write    = packet_q[P_WRITE];
    txn.datamode = packet_q[P_DMODE +: DMODE_W];
    txn.ctrlmode = packet_q[P_CMODE +: CMODE_W];
    txn.dstaddr  = packet_q[P_DST +: AW];   // register address lives here
    txn.data     = packet_q[P_DATA +: DW];  // write data
    txn.srcaddr  = packet_q[P_SRC +: AW];   // reply address
  end

endmodule

// File: sources.f
+incdir+bench
hdl/ecfg_pkg.sv
hdl/emesh_unpack.sv
hdl/ecfg_clocks.sv
hdl/ecfg_readback.sv
hdl/ecfg_top.sv
bench/ecfg_tb.sv
